// File: rtl/wb_pkg.sv
// writeback stage shared definitions
// word and segment types, flag bit positions in the flags register,
// pop restore masks and the flags value after reset

package wb_pkg;

	//------------------------------------------------------------
	// types
	//------------------------------------------------------------

	// data word for results, flags, eip and counts
	typedef logic [31:0] word_t;

	// segment selector
	typedef logic [15:0] seg_t;

	// affected mask with bits 6 down to 0 for of df sf zf af pf cf
	typedef logic [6:0] flags_affected_t;

	//------------------------------------------------------------
	// flag positions in the flags word
	//------------------------------------------------------------

	localparam int unsigned flag_cf = 0;
	localparam int unsigned flag_pf = 2;
	localparam int unsigned flag_af = 4;
	localparam int unsigned flag_zf = 6;
	localparam int unsigned flag_sf = 7;
	localparam int unsigned flag_df = 10;
	localparam int unsigned flag_of = 11;

	//------------------------------------------------------------
	// pop restore and reset values
	//------------------------------------------------------------

	// bits a popped word may write
	localparam word_t flags_pop_mask = 32'h00257FD5;
	// bits kept from the old flags on a pop
	localparam word_t flags_keep_mask = 32'h00A10000;
	// reserved bit 1 reads as one
	localparam word_t flags_reset = 32'h00000002;

endpackage

// File: rtl/wb_result_if.sv
// writeback operand bundle
// carries the selected data word, final eip and cs and the
// second cmps micro-op level from operand select to commit control

`timescale 1ns/1ps

interface wb_result_if;
	import wb_pkg::*;

	// data to write
	word_t data1;
	// next instruction pointer and code segment
	word_t final_eip;
	seg_t final_cs;
	// high on the second cmps micro-op
	logic cmps_second;

	// driven by the operand selector
	modport src (output data1, output final_eip, output final_cs, output cmps_second);
	// read by the commit controller
	modport dst (input data1, input final_eip, input final_cs, input cmps_second);

endinterface

// File: rtl/wb_flags_unit.sv
// writeback flags unit
// holds the architectural flags register and computes the flags
// after the current micro-op, either as an affected-mask merge of
// the alu flags or as a masked restore from a popped word

`timescale 1ns/1ps

module wb_flags_unit (
	input logic CLK,
	input logic rst_n,
	input logic ld_flags_v,
	input logic pop_flags,
	input wb_pkg::flags_affected_t flags_affected,
	input wb_pkg::word_t alu_flags,
	input wb_pkg::word_t result_a,
	output wb_pkg::word_t cur_flags
);
	import wb_pkg::*;

	// stored flags from earlier micro-ops
	word_t prev_flags;
	// affected mask spread out to flag positions
	word_t affected_bits;
	word_t merged_flags;
	word_t popped_flags;

	//------------------------------------------------------------
	// next flags value
	//------------------------------------------------------------

	always_comb
	begin
		affected_bits = '0;
		affected_bits[flag_of] = flags_affected[6];
		affected_bits[flag_df] = flags_affected[5];
		affected_bits[flag_sf] = flags_affected[4];
		affected_bits[flag_zf] = flags_affected[3];
		affected_bits[flag_af] = flags_affected[2];
		affected_bits[flag_pf] = flags_affected[1];
		affected_bits[flag_cf] = flags_affected[0];
	end

	// affected bits from the alu, rest from the old flags
	assign merged_flags = (prev_flags & ~affected_bits) | (alu_flags & affected_bits);

	// popf path takes only writable bits from the stack word
	assign popped_flags = (result_a & flags_pop_mask) | (prev_flags & flags_keep_mask);

	assign cur_flags = pop_flags ? popped_flags : merged_flags;

	//------------------------------------------------------------
	// flags register
	//------------------------------------------------------------

	// enable already carries the valid bit
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
			prev_flags <= flags_reset;
		else if (ld_flags_v)
			prev_flags <= cur_flags;
	end

endmodule

// File: rtl/wb_operand_select.sv
// writeback operand selector
// keeps the first cmps pointer and the temporary eip and cs saved
// for far transfers, and picks the data word, final eip and final
// cs that go on to commit control

`timescale 1ns/1ps

module wb_operand_select (
	input logic CLK,
	input logic rst_n,
	input logic cmps_first,
	input logic cmps_second,
	input logic push_flags,
	input logic save_neip,
	input logic save_ncs,
	input logic use_temp_neip,
	input logic use_temp_ncs,
	input wb_pkg::word_t result_a,
	input wb_pkg::word_t neip,
	input wb_pkg::seg_t ncs,
	input wb_pkg::word_t cur_flags,
	wb_result_if.src res
);
	import wb_pkg::*;

	// pointer from the first cmps micro-op
	word_t cmps_ptr;
	// saved eip and cs for far transfers
	word_t temp_eip;
	seg_t temp_cs;

	//------------------------------------------------------------
	// temporary registers
	//------------------------------------------------------------

	// these load without the valid bit
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			cmps_ptr <= '0;
			temp_eip <= '0;
			temp_cs <= '0;
		end
		else
		begin
			if (cmps_first)
				cmps_ptr <= result_a;
			if (save_neip)
				temp_eip <= neip;
			if (save_ncs)
				temp_cs <= ncs;
		end
	end

	//------------------------------------------------------------
	// selection
	//------------------------------------------------------------

	// second cmps uop wins over a flags push
	assign res.data1 = cmps_second ? cmps_ptr : (push_flags ? cur_flags : result_a);

	assign res.final_eip = use_temp_neip ? temp_eip : neip;
	assign res.final_cs = use_temp_ncs ? temp_cs : ncs;

	// commit control needs it for repne
	assign res.cmps_second = cmps_second;

endmodule

// File: rtl/wb_commit_control.sv
// writeback commit controller
// resolves conditional eip and gpr2 loads from the current flags,
// detects repne cmps termination and halt, gates every write enable
// with the valid bit and drives the write data, eip and cs

`timescale 1ns/1ps

module wb_commit_control (
	input logic valid,
	wb_result_if.dst res,
	input wb_pkg::word_t cur_flags,
	input wb_pkg::word_t result_c,
	input logic is_jne,
	input logic is_jnbe,
	input logic is_cmovc,
	input logic is_halt,
	input logic repne,
	input logic ld_eip,
	input logic ld_gpr1,
	input logic ld_gpr2,
	input logic ld_gpr3,
	input logic ld_seg,
	input logic ld_mm,
	input logic dcache_write,
	input logic ld_flags,
	input logic ld_cs,
	output logic ld_flags_v,
	output logic v_ld_gpr1,
	output logic v_ld_gpr2,
	output logic v_ld_gpr3,
	output logic v_ld_seg,
	output logic v_ld_mm,
	output logic v_dcache_write,
	output logic v_ld_flags_out,
	output logic v_ld_eip,
	output logic v_ld_cs,
	output logic halt,
	output logic repne_done,
	output wb_pkg::word_t wr_data,
	output wb_pkg::word_t wr_eip,
	output wb_pkg::seg_t wr_cs
);
	import wb_pkg::*;

	logic cf;
	logic zf;
	logic cond_ld_eip;
	logic cond_ld_gpr2;
	logic repne_second;
	logic count_zero;

	// flags after this uop rather than the stored ones
	assign cf = cur_flags[flag_cf];
	assign zf = cur_flags[flag_zf];

	//------------------------------------------------------------
	// conditional loads
	//------------------------------------------------------------

	// jnbe takes eip when above, jne when not equal
	assign cond_ld_eip = is_jnbe ? (~cf & ~zf) : (is_jne ? ~zf : ld_eip);

	// cmovc moves only on carry
	assign cond_ld_gpr2 = is_cmovc ? cf : ld_gpr2;

	//------------------------------------------------------------
	// repne cmps end and halt
	//------------------------------------------------------------

	assign repne_second = repne & res.cmps_second;
	assign count_zero = (result_c == '0);

	// stop on a match or when ecx runs out
	assign repne_done = valid & repne_second & (zf | count_zero);
	assign halt = valid & is_halt;

	//------------------------------------------------------------
	// valid gating
	//------------------------------------------------------------

	assign ld_flags_v = valid & ld_flags;
	assign v_ld_flags_out = valid & ld_flags;
	assign v_ld_gpr1 = valid & ld_gpr1;
	assign v_ld_gpr2 = valid & cond_ld_gpr2;
	assign v_ld_gpr3 = valid & ld_gpr3;
	assign v_ld_seg = valid & ld_seg;
	assign v_ld_mm = valid & ld_mm;
	assign v_dcache_write = valid & dcache_write;
	assign v_ld_cs = valid & ld_cs;

	// repne loop exits by loading the next eip
	assign v_ld_eip = repne_second ? repne_done : (valid & cond_ld_eip);

	// write data straight from the selector
	assign wr_data = res.data1;
	assign wr_eip = res.final_eip;
	assign wr_cs = res.final_cs;

endmodule

// File: rtl/wb_stage.sv
// writeback stage top level
// flags unit and operand selector work side by side, commit control
// combines their outputs into the final write enables and data

`timescale 1ns/1ps

module wb_stage (
	input logic CLK,
	input logic rst_n,
	input logic valid,
	input logic cmps_first,
	input logic cmps_second,
	input logic push_flags,
	input logic pop_flags,
	input logic save_neip,
	input logic save_ncs,
	input logic use_temp_neip,
	input logic use_temp_ncs,
	input wb_pkg::flags_affected_t flags_affected,
	input wb_pkg::word_t alu_flags,
	input wb_pkg::word_t result_a,
	input wb_pkg::word_t result_c,
	input wb_pkg::word_t neip,
	input wb_pkg::seg_t ncs,
	input logic is_jne,
	input logic is_jnbe,
	input logic is_cmovc,
	input logic is_halt,
	input logic repne,
	input logic ld_eip,
	input logic ld_gpr1,
	input logic ld_gpr2,
	input logic ld_gpr3,
	input logic ld_seg,
	input logic ld_mm,
	input logic dcache_write,
	input logic ld_flags,
	input logic ld_cs,
	output logic v_ld_gpr1,
	output logic v_ld_gpr2,
	output logic v_ld_gpr3,
	output logic v_ld_seg,
	output logic v_ld_mm,
	output logic v_dcache_write,
	output logic v_ld_flags_out,
	output logic v_ld_eip,
	output logic v_ld_cs,
	output logic halt,
	output logic repne_done,
	output wb_pkg::word_t wr_data,
	output wb_pkg::word_t wr_eip,
	output wb_pkg::seg_t wr_cs,
	output wb_pkg::word_t flags
);

	// flags register enable fed back from commit control
	logic ld_flags_v;

	// selected operands
	wb_result_if u_res ();

	//------------------------------------------------------------
	// flags and operands
	//------------------------------------------------------------

	// flags output is the combinational next value
	wb_flags_unit u_flags (
		.CLK(CLK),
		.rst_n(rst_n),
		.ld_flags_v(ld_flags_v),
		.pop_flags(pop_flags),
		.flags_affected(flags_affected),
		.alu_flags(alu_flags),
		.result_a(result_a),
		.cur_flags(flags)
	);

	wb_operand_select u_opsel (
		.CLK(CLK),
		.rst_n(rst_n),
		.cmps_first(cmps_first),
		.cmps_second(cmps_second),
		.push_flags(push_flags),
		.save_neip(save_neip),
		.save_ncs(save_ncs),
		.use_temp_neip(use_temp_neip),
		.use_temp_ncs(use_temp_ncs),
		.result_a(result_a),
		.neip(neip),
		.ncs(ncs),
		.cur_flags(flags),
		.res(u_res.src)
	);

	//------------------------------------------------------------
	// commit
	//------------------------------------------------------------

	wb_commit_control u_commit (
		.valid(valid),
		.res(u_res.dst),
		.cur_flags(flags),
		.result_c(result_c),
		.is_jne(is_jne),
		.is_jnbe(is_jnbe),
		.is_cmovc(is_cmovc),
		.is_halt(is_halt),
		.repne(repne),
		.ld_eip(ld_eip),
		.ld_gpr1(ld_gpr1),
		.ld_gpr2(ld_gpr2),
		.ld_gpr3(ld_gpr3),
		.ld_seg(ld_seg),
		.ld_mm(ld_mm),
		.dcache_write(dcache_write),
		.ld_flags(ld_flags),
		.ld_cs(ld_cs),
		.ld_flags_v(ld_flags_v),
		.v_ld_gpr1(v_ld_gpr1),
		.v_ld_gpr2(v_ld_gpr2),
		.v_ld_gpr3(v_ld_gpr3),
		.v_ld_seg(v_ld_seg),
		.v_ld_mm(v_ld_mm),
		.v_dcache_write(v_dcache_write),
		.v_ld_flags_out(v_ld_flags_out),
		.v_ld_eip(v_ld_eip),
		.v_ld_cs(v_ld_cs),
		.halt(halt),
		.repne_done(repne_done),
		.wr_data(wr_data),
		.wr_eip(wr_eip),
		.wr_cs(wr_cs)
	);

endmodule

// File: testbench/wb_stage_props.sv
// writeback stage properties
// valid gating, halt and repne cmps end conditions, flags after reset

`timescale 1ns/1ps

module wb_stage_props (
	input logic CLK,
	input logic rst_n,
	input logic valid,
	input logic is_halt,
	input logic halt,
	input logic repne_done,
	input wb_pkg::word_t result_c,
	input wb_pkg::word_t flags,
	input logic v_ld_gpr1, v_ld_gpr2, v_ld_gpr3, v_ld_seg, v_ld_mm, v_dcache_write,
	input logic v_ld_flags_out, v_ld_eip, v_ld_cs
);
	import wb_pkg::*;

	logic any_out;

	// every gated output at once
	assign any_out = v_ld_gpr1 | v_ld_gpr2 | v_ld_gpr3 | v_ld_seg | v_ld_mm | v_dcache_write |
		v_ld_flags_out | v_ld_eip | v_ld_cs | halt | repne_done;

	a_invalid_quiet: assert property (@(posedge CLK) disable iff (!rst_n) !valid |-> !any_out)
		else $error("an enable, halt or repne_done is high while valid is low");

	a_halt_src: assert property (@(posedge CLK) disable iff (!rst_n) halt |-> is_halt)
		else $error("halt is high without is_halt");

	// loop ends on a match or an exhausted count
	a_repne_end: assert property (@(posedge CLK) disable iff (!rst_n)
		repne_done |-> (flags[flag_zf] || result_c == '0))
		else $error("repne_done is high with ZF clear and a nonzero count");

	a_reset_flags: assert property (@(posedge CLK) $rose(rst_n) |-> flags == flags_reset)
		else $error("flags differ from the reset value after reset");

endmodule

// File: testbench/wb_checker.sv
// writeback stage output checker
// compares the dut outputs against the expected columns of the
// current vector on the falling edge, after the inputs have settled

`timescale 1ns/1ps

module wb_checker (
	input logic CLK,
	input logic check_en,
	input logic [10:0] exp_en,
	input wb_pkg::word_t exp_data,
	input wb_pkg::word_t exp_eip,
	input wb_pkg::seg_t exp_cs,
	input wb_pkg::word_t exp_flags,
	input logic v_ld_gpr1, v_ld_gpr2, v_ld_gpr3, v_ld_seg, v_ld_mm, v_dcache_write,
	input logic v_ld_flags_out, v_ld_eip, v_ld_cs, halt, repne_done,
	input wb_pkg::word_t wr_data,
	input wb_pkg::word_t wr_eip,
	input wb_pkg::seg_t wr_cs,
	input wb_pkg::word_t flags,
	output int unsigned err_count,
	output int unsigned check_count
);
	import wb_pkg::*;

	// enable names with the msb of the enable vector first
	string en_names [11] = '{"v_ld_gpr1", "v_ld_gpr2", "v_ld_gpr3", "v_ld_seg", "v_ld_mm",
		"v_dcache_write", "v_ld_flags_out", "v_ld_eip", "v_ld_cs", "halt", "repne_done"};

	logic [10:0] act_en;
	int unsigned errors = 0;
	int unsigned checks = 0;

	// same bit order as the en column of the vector file
	assign act_en = {v_ld_gpr1, v_ld_gpr2, v_ld_gpr3, v_ld_seg, v_ld_mm, v_dcache_write,
		v_ld_flags_out, v_ld_eip, v_ld_cs, halt, repne_done};

	assign err_count = errors;
	assign check_count = checks;

	task automatic compare_value(input string name, input word_t exp_val, input word_t act_val);
		if (act_val !== exp_val)
		begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
			errors++;
		end
	endtask

	//------------------------------------------------------------
	// compare on the falling edge
	//------------------------------------------------------------

	always @(negedge CLK)
	begin
		if (check_en)
		begin
			checks++;
			for (int i = 10; i >= 0; i--)
				compare_value(en_names[10 - i], word_t'(exp_en[i]), word_t'(act_en[i]));
			compare_value("wr_data", exp_data, wr_data);
			compare_value("wr_eip", exp_eip, wr_eip);
			compare_value("wr_cs", word_t'(exp_cs), word_t'(wr_cs));
			compare_value("flags", exp_flags, flags);
		end
	end

endmodule

// File: testbench/tb_wb_stage.sv
// testbench for the writeback stage
// reads one micro-op per line from the vector file, drives the
// dut on the rising edge and hands the expected columns to the checker

`timescale 1ns/1ps

module tb_wb_stage;
	import wb_pkg::*;

	// upper bound on lines read from the vector file
	localparam int max_lines = 200;

	logic CLK;
	logic rst_n;

	// dut inputs
	logic valid, cmps_first, cmps_second, push_flags, pop_flags;
	logic save_neip, save_ncs, use_temp_neip, use_temp_ncs;
	logic is_jne, is_jnbe, is_cmovc, is_halt, repne;
	logic ld_eip, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write, ld_flags, ld_cs;
	flags_affected_t flags_affected;
	word_t alu_flags, result_a, result_c, neip;
	seg_t ncs;

	// dut outputs
	logic v_ld_gpr1, v_ld_gpr2, v_ld_gpr3, v_ld_seg, v_ld_mm, v_dcache_write;
	logic v_ld_flags_out, v_ld_eip, v_ld_cs, halt, repne_done;
	word_t wr_data, wr_eip, flags;
	seg_t wr_cs;

	// expected values hold while check_en is high
	logic check_en;
	logic [10:0] exp_en;
	word_t exp_data, exp_eip, exp_flags;
	seg_t exp_cs;
	int unsigned err_count, check_count;

	// fields of one vector line
	int fd, n_fields, lines, applied, other_errors;
	string line;
	logic [4:0] f_ctl;
	logic [3:0] f_tmp;
	logic [4:0] f_cond;
	logic [8:0] f_ld;
	logic [10:0] f_en;
	flags_affected_t f_aff;
	word_t f_alu, f_ra, f_rc, f_neip, f_data, f_eip, f_flags;
	seg_t f_ncs, f_cs;

	wb_stage i_wb_stage (.*);
	wb_checker u_checker (.*);
	bind wb_stage wb_stage_props u_props (.*);

	always #5 CLK = ~CLK;

	// one micro-op plus its expected outputs
	task automatic drive_vector();
		@(posedge CLK);
		{valid, cmps_first, cmps_second, push_flags, pop_flags} <= f_ctl;
		{save_neip, save_ncs, use_temp_neip, use_temp_ncs} <= f_tmp;
		{is_jne, is_jnbe, is_cmovc, is_halt, repne} <= f_cond;
		{ld_eip, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write, ld_flags, ld_cs} <= f_ld;
		flags_affected <= f_aff;
		alu_flags <= f_alu;
		result_a <= f_ra;
		result_c <= f_rc;
		neip <= f_neip;
		ncs <= f_ncs;
		exp_en <= f_en;
		exp_data <= f_data;
		exp_eip <= f_eip;
		exp_cs <= f_cs;
		exp_flags <= f_flags;
		check_en <= 1'b1;
	endtask

	initial
	begin
		CLK = 1'b0;
		rst_n = 1'b0;
		{valid, cmps_first, cmps_second, push_flags, pop_flags} = '0;
		{save_neip, save_ncs, use_temp_neip, use_temp_ncs} = '0;
		{is_jne, is_jnbe, is_cmovc, is_halt, repne} = '0;
		{ld_eip, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, dcache_write, ld_flags, ld_cs} = '0;
		flags_affected = '0;
		{alu_flags, result_a, result_c, neip, ncs} = '0;
		{check_en, exp_en, exp_data, exp_eip, exp_cs, exp_flags} = '0;
		lines = 0;
		applied = 0;
		other_errors = 0;

		// reset, then a couple of idle cycles
		repeat (10) @(posedge CLK);
		rst_n <= 1'b1;
		repeat (2) @(posedge CLK);

		fd = $fopen("testbench/wb_stage_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test vector file");
			other_errors++;
		end
		else
		begin
			while (!$feof(fd) && lines < max_lines)
			begin
				lines++;
				n_fields = $fgets(line, fd);
				if (n_fields == 0 || line.len() == 0 || line.getc(0) == "#")
					continue;
				n_fields = $sscanf(line, "%b %b %b %b %b %h %h %h %h %h %b %h %h %h %h",
					f_ctl, f_tmp, f_cond, f_ld, f_aff, f_alu, f_ra, f_rc, f_neip, f_ncs,
					f_en, f_data, f_eip, f_cs, f_flags);
				if (n_fields == 15)
				begin
					drive_vector();
					applied++;
				end
				else if (n_fields > 0)
				begin
					$display("vector line %0d is incomplete and was skipped", lines);
					other_errors++;
				end
			end
			if (!$feof(fd))
			begin
				$display("vector loop timed out after %0d lines", lines);
				other_errors++;
			end
			$fclose(fd);
		end

		// let the last vector be checked
		@(posedge CLK);
		check_en <= 1'b0;
		valid <= 1'b0;
		@(negedge CLK);
		if (applied == 0)
		begin
			$display("no test vectors were applied");
			other_errors++;
		end

		$display("error counts: %0d mismatches in %0d checked vectors, %0d other failures",
			err_count, check_count, other_errors);
		if (err_count == 0 && other_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: testbench/wb_stage_tests.txt
# ctl(valid cmps1 cmps2 push pop) tmp(save_eip save_cs use_eip use_cs) cond(jne jnbe cmovc halt repne)
# ld(eip gpr1 gpr2 gpr3 seg mm dwr flg cs) aff alu a c neip ncs | en(gpr1..cs halt done) data eip cs fl
00000 0000 00000 000000000 0000000 0 0 0 0 0 00000000000 0 0 0 2
10000 0000 00000 010000010 0001001 ffffffff 12345678 0 1000 8 10000010000 12345678 1000 8 43
10000 0000 00000 000000000 0000000 0 0 0 0 0 00000000000 0 0 0 43
00000 0000 00010 111111111 1111111 0 deadbeef 0 2000 10 00000000000 deadbeef 2000 10 2
10000 0000 00000 000000000 0000000 0 0 0 0 0 00000000000 0 0 0 43
10001 0000 00000 000000010 0000000 0 ffffffff 0 0 0 00000010000 ffffffff 0 0 257fd5
10001 0000 00000 000000010 0000000 0 0 0 0 0 00000010000 0 0 0 210000
10000 0000 10000 000000000 0001001 0 0 0 3000 0 00000001000 0 3000 0 210000
10000 0000 10000 100000000 0001001 40 0 0 3000 0 00000000000 0 3000 0 210040
10000 0000 01000 000000000 0001001 0 0 0 3000 0 00000001000 0 3000 0 210000
10000 0000 01000 000000000 0001001 1 0 0 3000 0 00000000000 0 3000 0 210001
10000 0000 01000 000000000 0001001 40 0 0 3000 0 00000000000 0 3000 0 210040
10000 0000 00100 000000000 0001001 1 0 0 0 0 01000000000 0 0 0 210001
10000 0000 00100 001000000 0001001 0 0 0 0 0 00000000000 0 0 0 210000
10000 0000 00000 101000000 0001001 0 0 0 0 0 01000001000 0 0 0 210000
11000 0000 00000 010000000 0000000 0 400100 5 0 0 10000000000 400100 0 0 210000
10100 0000 00001 100000000 0001001 0 500200 4 0 0 00000000000 400100 0 0 210000
10100 0000 00001 100000000 0001001 40 500200 4 0 0 00000001001 400100 0 0 210040
10100 0000 00001 100000000 0001001 0 500200 0 0 0 00000001001 400100 0 0 210000
10000 1100 00000 100000001 0000000 0 0 0 c0de0010 23 00000001100 0 c0de0010 23 210000
10010 0011 00000 100000101 0000000 0 99999999 0 11110000 8 00000101100 210000 c0de0010 23 210000
10000 0000 00010 000000000 0000000 0 0 0 0 0 00000000010 0 0 0 210000
00100 0000 11111 111111111 0000000 0 0 0 0 0 00000000000 400100 0 0 210000

// File: wb_stage.f
rtl/wb_pkg.sv
rtl/wb_result_if.sv
rtl/wb_flags_unit.sv
rtl/wb_operand_select.sv
rtl/wb_commit_control.sv
rtl/wb_stage.sv
testbench/wb_stage_props.sv
testbench/wb_checker.sv
testbench/tb_wb_stage.sv

// File: Bender.yml
package:
  name: wb_stage

sources:
  - files:
      - rtl/wb_pkg.sv
      - rtl/wb_result_if.sv
      - rtl/wb_flags_unit.sv
      - rtl/wb_operand_select.sv
      - rtl/wb_commit_control.sv
      - rtl/wb_stage.sv
  - target: test
    files:
      - testbench/wb_stage_props.sv
      - testbench/wb_checker.sv
      - testbench/tb_wb_stage.sv
